//--- logic/apb_region_decode.sv
`timescale 1ns/1ns

module apb_region_decode
(
    input  logic                    pclk,
    input  logic                    s_pclk_rstn,
    input  pcie_app_pkg::apb_req_t  i_apb_req,
    input  logic                    i_apb_sel,
    input  logic                    i_pcie_rdy,
    input  pcie_app_pkg::apb_data_t i_pcie_rdata,
    input  logic                    i_dma_rdy,
    input  pcie_app_pkg::apb_data_t i_dma_rdata,
    input  pcie_app_pkg::apb_data_t i_cfg_rdata,
    output logic                    o_apb_rdy,
    output pcie_app_pkg::apb_data_t o_apb_rdata,
    output logic                    o_pcie_sel,
    output logic                    o_dma_sel,
    output logic                    o_cfg_sel,
    output pcie_app_pkg::apb_req_t  o_pcie_req,
    output pcie_app_pkg::apb_req_t  o_dma_req
);
    import pcie_app_pkg::*;

    logic [3:0] region;
    logic [2:0] hit;        // {cfg, dma, pcie}
    logic [2:0] hit_q;      // region held from the setup phase
    logic [2:0] sel_vec;

    assign region = i_apb_req.addr[APB_ADDR_W-1 -: 4];
    assign hit    = {region == REGION_CFG, region == REGION_DMA, region == REGION_PCIE};

    always_ff @(posedge pclk or negedge s_pclk_rstn)
    begin
        if (!s_pclk_rstn)
            hit_q <= 3'b000;
        else if (i_apb_sel && !i_apb_req.enable)
            hit_q <= hit;   // latch at setup
    end

    assign sel_vec    = i_apb_sel ? (i_apb_req.enable ? hit_q : hit) : 3'b000;
    assign o_pcie_sel = sel_vec[0];
    assign o_dma_sel  = sel_vec[1];
    assign o_cfg_sel  = sel_vec[2];

    assign o_pcie_req = i_apb_req;
    assign o_dma_req  = i_apb_req;

    // cfg and unmapped regions complete in the first access cycle
    always_comb
    begin
        o_apb_rdy   = i_apb_sel & i_apb_req.enable;
        o_apb_rdata = '0;   // unmapped reads zero
        if (sel_vec[0])
        begin
            o_apb_rdy   = o_apb_rdy & i_pcie_rdy;
            o_apb_rdata = i_pcie_rdata;
        end
        else if (sel_vec[1])
        begin
            o_apb_rdy   = o_apb_rdy & i_dma_rdy;
            o_apb_rdata = i_dma_rdata;
        end
        else if (sel_vec[2])
            o_apb_rdata = i_cfg_rdata;
    end

endmodule

//--- logic/axis_path_steer.sv
`timescale 1ns/1ns

module axis_path_steer
(
    input  logic                        i_enable,
    input  pcie_app_pkg::axis_tx_beat_t i_fsm_s0_beat,
    input  logic                        i_fsm_s0_vld,
    input  logic                        i_fsm_m_rdy,
    input  pcie_app_pkg::axis_tx_beat_t i_dma_s0_beat,
    input  logic                        i_dma_s0_vld,
    input  logic                        i_dma_m_rdy,
    input  logic                        i_core_s0_rdy,
    input  pcie_app_pkg::axis_rx_beat_t i_core_m_beat,
    input  logic                        i_core_m_vld,
    output pcie_app_pkg::axis_tx_beat_t o_core_s0_beat,
    output logic                        o_core_s0_vld,
    output logic                        o_core_m_rdy,
    output logic                        o_dma_s0_rdy,
    output pcie_app_pkg::axis_rx_beat_t o_dma_m_beat,
    output logic                        o_dma_m_vld,
    output logic                        o_fsm_s0_rdy,
    output logic                        o_fsm_m_vld
);

    // ********************
    // slave channel 0
    assign o_core_s0_beat = i_enable ? i_fsm_s0_beat : i_dma_s0_beat;
    assign o_core_s0_vld  = i_enable ? i_fsm_s0_vld  : i_dma_s0_vld;
    assign o_fsm_s0_rdy   = i_enable & i_core_s0_rdy;
    assign o_dma_s0_rdy   = ~i_enable & i_core_s0_rdy;

    // ********************
    // master channel, dma sees nothing while cfg owns it
    assign o_dma_m_beat = i_enable ? '0 : i_core_m_beat;
    assign o_dma_m_vld  = ~i_enable & i_core_m_vld;
    assign o_fsm_m_vld  = i_enable & i_core_m_vld;
    assign o_core_m_rdy = i_enable ? i_fsm_m_rdy : i_dma_m_rdy;

endmodule

//--- logic/cfg_tlp_fsm.sv
`timescale 1ns/1ns

module cfg_tlp_fsm
(
    input  logic                        pclk,
    input  logic                        s_pclk_rstn,
    input  logic                        i_enable,
    input  logic                        i_start,
    input  pcie_app_pkg::axis_data_t    i_tx_header,
    input  logic                        i_s0_rdy,
    input  logic                        i_m_vld,
    input  pcie_app_pkg::axis_rx_beat_t i_m_beat,
    output logic                        o_busy,
    output pcie_app_pkg::axis_tx_beat_t o_s0_beat,
    output logic                        o_s0_vld,
    output logic                        o_m_rdy,
    output logic                        o_cpl_wr,
    output pcie_app_pkg::axis_rx_beat_t o_cpl_beat
);
    import pcie_app_pkg::*;

    cfg_tlp_state_t state;
    cfg_tlp_state_t state_nxt;

    always_comb
    begin
        state_nxt = state;
        if (!i_enable)
            state_nxt = ST_IDLE;   // abort, done stays clear
        else
        begin
            case (state)
                ST_IDLE:     if (i_start) state_nxt = ST_SEND;
                ST_SEND:     if (i_s0_rdy) state_nxt = ST_WAIT_CPL;
                ST_WAIT_CPL: if (i_m_vld && i_m_beat.last) state_nxt = ST_IDLE;
                default:     state_nxt = ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge pclk or negedge s_pclk_rstn)
    begin
        if (!s_pclk_rstn)
            state <= ST_IDLE;
        else
            state <= state_nxt;
    end

    // request is a single beat
    assign o_s0_vld       = (state == ST_SEND);
    assign o_s0_beat.data = i_tx_header;
    assign o_s0_beat.last = 1'b1;
    assign o_s0_beat.user = 1'b0;

    assign o_m_rdy    = (state == ST_WAIT_CPL);
    assign o_cpl_wr   = o_m_rdy & i_m_vld;   // accepted completion beat
    assign o_cpl_beat = i_m_beat;
    assign o_busy     = (state != ST_IDLE);

endmodule

//--- logic/cfg_tlp_regs.sv
`timescale 1ns/1ns

module cfg_tlp_regs
(
    input  logic                        pclk,
    input  logic                        s_pclk_rstn,
    input  pcie_app_pkg::apb_req_t      i_apb_req,
    input  logic                        i_cfg_sel,
    input  logic                        i_busy,
    input  logic                        i_cpl_wr,
    input  pcie_app_pkg::axis_rx_beat_t i_cpl_beat,
    output pcie_app_pkg::apb_data_t     o_rdata,
    output logic                        o_enable,
    output logic                        o_start,
    output pcie_app_pkg::axis_data_t    o_tx_header
);
    import pcie_app_pkg::*;

    logic [7:0] offset;
    logic [1:0] idx;        // word within header or completion
    logic       wr_en;
    logic       wr_ctrl;
    logic       wr_hdr;
    logic       start_wr;

    logic       enable_q;
    logic       start_q;
    logic       done_q;
    axis_data_t tx_hdr_q;
    axis_data_t cpl_q;

    assign offset   = i_apb_req.addr[7:0];
    assign idx      = offset[3:2];
    assign wr_en    = i_cfg_sel & i_apb_req.enable & i_apb_req.write;
    assign wr_ctrl  = wr_en & (offset == CFG_REG_CTRL);
    assign wr_hdr   = wr_en & (offset[7:4] == CFG_REG_TX_BASE[7:4]);
    assign start_wr = wr_ctrl & i_apb_req.strb[0] & i_apb_req.wdata[1];

    // ********************
    // control and status
    always_ff @(posedge pclk or negedge s_pclk_rstn)
    begin
        if (!s_pclk_rstn)
        begin
            enable_q <= 1'b0;
            start_q  <= 1'b0;
            done_q   <= 1'b0;
        end
        else
        begin
            start_q <= start_wr;   // one-cycle pulse
            if (wr_ctrl && i_apb_req.strb[0])
                enable_q <= i_apb_req.wdata[0];
            if (i_cpl_wr && i_cpl_beat.last)
                done_q <= 1'b1;
            else if (start_wr)
                done_q <= 1'b0;
        end
    end

    // ********************
    // header and completion words
    always_ff @(posedge pclk or negedge s_pclk_rstn)
    begin
        if (!s_pclk_rstn)
        begin
            tx_hdr_q <= '0;
            cpl_q    <= '0;
        end
        else
        begin
            for (int b = 0; b < APB_STRB_W; b++)
            begin
                if (wr_hdr && i_apb_req.strb[b])
                    tx_hdr_q[idx*APB_DATA_W + b*8 +: 8] <= i_apb_req.wdata[b*8 +: 8];
            end
            if (i_cpl_wr)
                cpl_q <= i_cpl_beat.data;   // last beat wins
        end
    end

    always_comb
    begin
        o_rdata = '0;
        if (offset == CFG_REG_CTRL)
            o_rdata = {{(APB_DATA_W-4){1'b0}}, done_q, i_busy, 1'b0, enable_q};
        else if (offset[7:4] == CFG_REG_TX_BASE[7:4])
            o_rdata = tx_hdr_q[idx*APB_DATA_W +: APB_DATA_W];
        else if (offset[7:4] == CFG_REG_RX_BASE[7:4])
            o_rdata = cpl_q[idx*APB_DATA_W +: APB_DATA_W];
    end

    assign o_enable    = enable_q;
    assign o_start     = start_q;
    assign o_tx_header = tx_hdr_q;

endmodule

//--- logic/led_heartbeat.sv
`timescale 1ns/1ns

module led_heartbeat
(
    input  logic pclk,
    input  logic s_pclk_rstn,
    output logic o_led
);
    import pcie_app_pkg::*;

    logic [HEARTBEAT_W-1:0] cnt;

    always_ff @(posedge pclk or negedge s_pclk_rstn)
    begin
        if (!s_pclk_rstn)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;   // free running
    end

    always_ff @(posedge pclk or negedge s_pclk_rstn)
    begin
        if (!s_pclk_rstn)
            o_led <= 1'b1;
        else if (&cnt)
            o_led <= ~o_led;     // once per wrap
    end

endmodule

//--- logic/pcie_app_pkg.sv
package pcie_app_pkg;

    // ********************
    // bus widths
    localparam int APB_ADDR_W   = 16;
    localparam int APB_DATA_W   = 32;
    localparam int APB_STRB_W   = 4;
    localparam int AXIS_DATA_W  = 128;
    localparam int AXIS_KEEP_W  = 4;
    localparam int AXIS_MUSER_W = 8;

    // ********************
    // register map
    localparam logic [3:0] REGION_PCIE = 4'h7;       // pcie core dbi
    localparam logic [3:0] REGION_DMA  = 4'h8;       // dma engine
    localparam logic [3:0] REGION_CFG  = 4'h9;       // cfg tlp block

    localparam logic [7:0] CFG_REG_CTRL    = 8'h00;  // enable/start/busy/done
    localparam logic [7:0] CFG_REG_TX_BASE = 8'h10;  // header words 0..3
    localparam logic [7:0] CFG_REG_RX_BASE = 8'h20;  // completion words 0..3

    localparam int HEARTBEAT_W = 6;                  // short count for sim

    typedef logic [APB_ADDR_W-1:0]  apb_addr_t;
    typedef logic [APB_DATA_W-1:0]  apb_data_t;
    typedef logic [APB_STRB_W-1:0]  apb_strb_t;
    typedef logic [AXIS_DATA_W-1:0] axis_data_t;

    typedef struct packed {
        apb_addr_t addr;
        apb_data_t wdata;
        apb_strb_t strb;
        logic      write;
        logic      enable;                           // low in setup phase
    } apb_req_t;

    typedef struct packed {
        axis_data_t data;
        logic       last;
        logic       user;
    } axis_tx_beat_t;

    typedef struct packed {
        axis_data_t              data;
        logic [AXIS_KEEP_W-1:0]  keep;
        logic                    last;
        logic [AXIS_MUSER_W-1:0] user;
    } axis_rx_beat_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_WAIT_CPL
    } cfg_tlp_state_t;

endpackage

//--- logic/pcie_app_top.sv
`timescale 1ns/1ns

module pcie_app_top
(
    input  logic                        pclk,
    input  logic                        s_pclk_rstn,
    // apb from the external master
    input  pcie_app_pkg::apb_req_t      i_apb_req,
    input  logic                        i_apb_sel,
    output logic                        o_apb_rdy,
    output pcie_app_pkg::apb_data_t     o_apb_rdata,
    // apb to pcie core and dma engine
    output pcie_app_pkg::apb_req_t      o_pcie_apb_req,
    output logic                        o_pcie_apb_sel,
    input  logic                        i_pcie_apb_rdy,
    input  pcie_app_pkg::apb_data_t     i_pcie_apb_rdata,
    output pcie_app_pkg::apb_req_t      o_dma_apb_req,
    output logic                        o_dma_apb_sel,
    input  logic                        i_dma_apb_rdy,
    input  pcie_app_pkg::apb_data_t     i_dma_apb_rdata,
    // core stream side
    output pcie_app_pkg::axis_tx_beat_t o_core_s0_beat,
    output logic                        o_core_s0_vld,
    input  logic                        i_core_s0_rdy,
    input  pcie_app_pkg::axis_rx_beat_t i_core_m_beat,
    input  logic                        i_core_m_vld,
    output logic                        o_core_m_rdy,
    // dma stream side
    input  pcie_app_pkg::axis_tx_beat_t i_dma_s0_beat,
    input  logic                        i_dma_s0_vld,
    output logic                        o_dma_s0_rdy,
    output pcie_app_pkg::axis_rx_beat_t o_dma_m_beat,
    output logic                        o_dma_m_vld,
    input  logic                        i_dma_m_rdy,
    output logic                        o_heartbeat_led
);
    import pcie_app_pkg::*;

    logic          cfg_sel;
    apb_data_t     cfg_rdata;
    logic          cfg_enable;
    logic          cfg_start;
    axis_data_t    tx_header;
    logic          fsm_busy;
    logic          cpl_wr;
    axis_rx_beat_t cpl_beat;
    axis_tx_beat_t fsm_s0_beat;
    logic          fsm_s0_vld;
    logic          fsm_s0_rdy;
    logic          fsm_m_rdy;
    logic          fsm_m_vld;

    // ********************
    // register bus
    apb_region_decode u_apb_region_decode (
        .pclk         (pclk            ),
        .s_pclk_rstn  (s_pclk_rstn     ),
        .i_apb_req    (i_apb_req       ),
        .i_apb_sel    (i_apb_sel       ),
        .i_pcie_rdy   (i_pcie_apb_rdy  ),
        .i_pcie_rdata (i_pcie_apb_rdata),
        .i_dma_rdy    (i_dma_apb_rdy   ),
        .i_dma_rdata  (i_dma_apb_rdata ),
        .i_cfg_rdata  (cfg_rdata       ),
        .o_apb_rdy    (o_apb_rdy       ),
        .o_apb_rdata  (o_apb_rdata     ),
        .o_pcie_sel   (o_pcie_apb_sel  ),
        .o_dma_sel    (o_dma_apb_sel   ),
        .o_cfg_sel    (cfg_sel         ),
        .o_pcie_req   (o_pcie_apb_req  ),
        .o_dma_req    (o_dma_apb_req   )
    );

    cfg_tlp_regs u_cfg_tlp_regs (
        .pclk        (pclk       ),
        .s_pclk_rstn (s_pclk_rstn),
        .i_apb_req   (i_apb_req  ),
        .i_cfg_sel   (cfg_sel    ),
        .i_busy      (fsm_busy   ),
        .i_cpl_wr    (cpl_wr     ),
        .i_cpl_beat  (cpl_beat   ),
        .o_rdata     (cfg_rdata  ),
        .o_enable    (cfg_enable ),
        .o_start     (cfg_start  ),
        .o_tx_header (tx_header  )
    );

    // ********************
    // cfg tlp sequencer and stream mux
    cfg_tlp_fsm u_cfg_tlp_fsm (
        .pclk        (pclk       ),
        .s_pclk_rstn (s_pclk_rstn),
        .i_enable    (cfg_enable ),
        .i_start     (cfg_start  ),
        .i_tx_header (tx_header  ),
        .i_s0_rdy    (fsm_s0_rdy ),
        .i_m_vld     (fsm_m_vld  ),
        .i_m_beat    (i_core_m_beat),
        .o_busy      (fsm_busy   ),
        .o_s0_beat   (fsm_s0_beat),
        .o_s0_vld    (fsm_s0_vld ),
        .o_m_rdy     (fsm_m_rdy  ),
        .o_cpl_wr    (cpl_wr     ),
        .o_cpl_beat  (cpl_beat   )
    );

    axis_path_steer u_axis_path_steer (
        .i_enable       (cfg_enable    ),
        .i_fsm_s0_beat  (fsm_s0_beat   ),
        .i_fsm_s0_vld   (fsm_s0_vld    ),
        .i_fsm_m_rdy    (fsm_m_rdy     ),
        .i_dma_s0_beat  (i_dma_s0_beat ),
        .i_dma_s0_vld   (i_dma_s0_vld  ),
        .i_dma_m_rdy    (i_dma_m_rdy   ),
        .i_core_s0_rdy  (i_core_s0_rdy ),
        .i_core_m_beat  (i_core_m_beat ),
        .i_core_m_vld   (i_core_m_vld  ),
        .o_core_s0_beat (o_core_s0_beat),
        .o_core_s0_vld  (o_core_s0_vld ),
        .o_core_m_rdy   (o_core_m_rdy  ),
        .o_dma_s0_rdy   (o_dma_s0_rdy  ),
        .o_dma_m_beat   (o_dma_m_beat  ),
        .o_dma_m_vld    (o_dma_m_vld   ),
        .o_fsm_s0_rdy   (fsm_s0_rdy    ),
        .o_fsm_m_vld    (fsm_m_vld     )
    );

    led_heartbeat u_led_heartbeat (
        .pclk        (pclk           ),
        .s_pclk_rstn (s_pclk_rstn    ),
        .o_led       (o_heartbeat_led)
    );

endmodule

//--- pcie_app.f
logic/pcie_app_pkg.sv
logic/apb_region_decode.sv
logic/cfg_tlp_regs.sv
logic/cfg_tlp_fsm.sv
logic/axis_path_steer.sv
logic/led_heartbeat.sv
logic/pcie_app_top.sv
tests/tb_clk_gen.sv
tests/pcie_app_tb.sv

//--- tests/pcie_app_tb.sv
`timescale 1ns/1ns

module pcie_app_tb;
    import pcie_app_pkg::*;

    localparam int N_APB     = 200;
    localparam int N_CFG     = 60;
    localparam int N_STEER   = 100;
    localparam int HB_CYCLES = 9 * 64;
    localparam int EST_CYCLES = HB_CYCLES + N_APB*6 + N_CFG*6 + N_STEER*2 + 400;
    localparam int WATCHDOG_CYCLES = EST_CYCLES * 4;

    logic          pclk;
    logic          s_pclk_rstn;
    apb_req_t      i_apb_req;
    logic          i_apb_sel;
    logic          i_pcie_apb_rdy;
    apb_data_t     i_pcie_apb_rdata;
    logic          i_dma_apb_rdy;
    apb_data_t     i_dma_apb_rdata;
    logic          i_core_s0_rdy;
    axis_rx_beat_t i_core_m_beat;
    logic          i_core_m_vld;
    axis_tx_beat_t i_dma_s0_beat;
    logic          i_dma_s0_vld;
    logic          i_dma_m_rdy;
    logic          o_apb_rdy;
    apb_data_t     o_apb_rdata;
    apb_req_t      o_pcie_apb_req;
    logic          o_pcie_apb_sel;
    apb_req_t      o_dma_apb_req;
    logic          o_dma_apb_sel;
    axis_tx_beat_t o_core_s0_beat;
    logic          o_core_s0_vld;
    logic          o_core_m_rdy;
    logic          o_dma_s0_rdy;
    axis_rx_beat_t o_dma_m_beat;
    logic          o_dma_m_vld;
    logic          o_heartbeat_led;

    logic [31:0] rng_state = 32'd60886;
    int          check_cnt = 0;
    int          err_cnt = 0;
    int          test_err_base = 0;

    // reference model of the cfg register block
    logic        model_enable = 1'b0;
    logic        model_done = 1'b0;
    logic        model_busy = 1'b0;
    apb_data_t   model_hdr [4] = '{default: '0};
    axis_data_t  model_cpl = '0;

    tb_clk_gen u_tb_clk_gen (
        .pclk        (pclk       ),
        .s_pclk_rstn (s_pclk_rstn)
    );

    pcie_app_top pcie_app_top_inst (.*);

    // ********************
    // helpers
    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic axis_data_t rand_data();
        return {xorshift32(), xorshift32(), xorshift32(), xorshift32()};
    endfunction

    function automatic axis_tx_beat_t rand_tx_beat();
        logic [31:0] r;
        r = xorshift32();
        return {rand_data(), r[1:0]};
    endfunction

    function automatic axis_rx_beat_t rand_rx_beat();
        logic [31:0] r;
        r = xorshift32();
        return {rand_data(), r[3:0], r[4], r[15:8]};    // data keep last user
    endfunction

    task automatic next_cycle();
        @(posedge pclk);
        #1;
    endtask

    task automatic check_eq(input string name, input logic [159:0] exp, input logic [159:0] act);
        check_cnt++;
        if (act !== exp)
        begin
            err_cnt++;
            $display("Error: %s expected 0x%0h got 0x%0h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic report_failure(input string what);
        err_cnt++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    task automatic report_test(input string name);
        $display("test %-10s finished, %0d errors", name, err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    // ********************
    // register map model
    function automatic axis_data_t model_header();
        return {model_hdr[3], model_hdr[2], model_hdr[1], model_hdr[0]};
    endfunction

    function automatic apb_data_t model_cfg_read(input logic [7:0] offset);
        if (offset == CFG_REG_CTRL)
            return {28'h0, model_done, model_busy, 1'b0, model_enable};   // start reads 0
        else if (offset[7:4] == CFG_REG_TX_BASE[7:4])
            return model_hdr[offset[3:2]];
        else if (offset[7:4] == CFG_REG_RX_BASE[7:4])
            return model_cpl[offset[3:2]*32 +: 32];
        return '0;
    endfunction

    task automatic model_cfg_write(input logic [7:0] offset, input apb_data_t data,
                                   input apb_strb_t strb);
        int b;
        if (offset == CFG_REG_CTRL && strb[0])
        begin
            model_enable = data[0];
            if (data[1])
                model_done = 1'b0;    // start clears done
        end
        else if (offset[7:4] == CFG_REG_TX_BASE[7:4])
        begin
            for (b = 0; b < 4; b++)
                if (strb[b])
                    model_hdr[offset[3:2]][b*8 +: 8] = data[b*8 +: 8];
        end
    endtask

    // ********************
    // apb master with pcie and dma responders
    task automatic check_selects(input logic [3:0] region);
        check_eq("o_pcie_apb_sel", region == REGION_PCIE, o_pcie_apb_sel);
        check_eq("o_dma_apb_sel", region == REGION_DMA, o_dma_apb_sel);
        check_eq("o_pcie_apb_req", i_apb_req, o_pcie_apb_req);
        check_eq("o_dma_apb_req", i_apb_req, o_dma_apb_req);
    endtask

    task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                              input apb_strb_t strb, output apb_data_t rdata);
        logic [3:0] region;
        logic       is_ext;
        int         wait_cycles;
        int         k;
        apb_data_t  resp_data;
        apb_data_t  other_data;
        region      = addr[15:12];
        is_ext      = (region == REGION_PCIE) || (region == REGION_DMA);
        wait_cycles = is_ext ? int'(xorshift32() % 4) : 0;
        resp_data   = xorshift32();
        other_data  = xorshift32();
        rdata       = '0;
        i_apb_req.addr   = addr;    // setup phase
        i_apb_req.wdata  = wdata;
        i_apb_req.strb   = strb;
        i_apb_req.write  = wr;
        i_apb_req.enable = 1'b0;
        i_apb_sel        = 1'b1;
        #1;
        check_selects(region);
        check_eq("o_apb_rdy", 1'b0, o_apb_rdy);
        next_cycle();
        i_apb_req.enable = 1'b1;
        k = 0;
        while (1)
        begin
            i_pcie_apb_rdy   = (region == REGION_PCIE) && (k == wait_cycles);
            i_dma_apb_rdy    = (region == REGION_DMA) && (k == wait_cycles);
            i_pcie_apb_rdata = (region == REGION_PCIE) ? resp_data : other_data;
            i_dma_apb_rdata  = (region == REGION_DMA) ? resp_data : other_data;
            #1;
            check_selects(region);
            check_eq("o_apb_rdy", k == wait_cycles, o_apb_rdy);
            if (k == wait_cycles)
            begin
                rdata = o_apb_rdata;
                if (!wr && is_ext)
                    check_eq("o_apb_rdata", resp_data, rdata);
                else if (!wr && region != REGION_CFG)
                    check_eq("o_apb_rdata", 32'h0, rdata);    // unmapped
                break;
            end
            next_cycle();
            k++;
        end
        next_cycle();
        i_apb_sel        = 1'b0;
        i_apb_req.enable = 1'b0;
        i_pcie_apb_rdy   = 1'b0;
        i_dma_apb_rdy    = 1'b0;
    endtask

    task automatic cfg_write(input logic [7:0] offset, input apb_data_t data,
                             input apb_strb_t strb);
        apb_data_t rd;
        apb_access(1'b1, {REGION_CFG, 4'h0, offset}, data, strb, rd);
        model_cfg_write(offset, data, strb);
    endtask

    task automatic cfg_read(input logic [7:0] offset, output apb_data_t data);
        apb_access(1'b0, {REGION_CFG, 4'h0, offset}, xorshift32(), 4'h0, data);
    endtask

    task automatic cfg_read_check(input logic [7:0] offset);
        apb_data_t rd;
        cfg_read(offset, rd);
        check_eq("o_apb_rdata", model_cfg_read(offset), rd);
    endtask

    // ********************
    // stream helpers
    task automatic check_steer_cycles(input int n);
        logic [31:0] r;
        int          i;
        for (i = 0; i < n; i++)
        begin
            r = xorshift32();
            i_dma_s0_beat = rand_tx_beat();
            i_core_m_beat = rand_rx_beat();
            i_dma_s0_vld  = r[0];
            i_core_s0_rdy = r[1];
            i_core_m_vld  = r[2];
            i_dma_m_rdy   = r[3];
            #1;
            check_eq("o_core_s0_beat", i_dma_s0_beat, o_core_s0_beat);
            check_eq("o_core_s0_vld", i_dma_s0_vld, o_core_s0_vld);
            check_eq("o_dma_s0_rdy", i_core_s0_rdy, o_dma_s0_rdy);
            check_eq("o_dma_m_beat", i_core_m_beat, o_dma_m_beat);
            check_eq("o_dma_m_vld", i_core_m_vld, o_dma_m_vld);
            check_eq("o_core_m_rdy", i_dma_m_rdy, o_core_m_rdy);
            next_cycle();
        end
        i_dma_s0_vld = 1'b0;
        i_core_m_vld = 1'b0;
    endtask

    task automatic send_request();
        logic [31:0] r;
        logic        accepted;
        int          i;
        accepted = 1'b0;
        for (i = 0; i < 50 && !accepted; i++)
        begin
            r = xorshift32();
            i_core_s0_rdy = r[0];    // random core back-pressure
            i_dma_s0_vld  = r[1];
            i_dma_s0_beat = rand_tx_beat();
            #1;
            check_eq("o_dma_s0_rdy", 1'b0, o_dma_s0_rdy);
            if (o_core_s0_vld)
                check_eq("o_core_s0_beat", {model_header(), 1'b1, 1'b0}, o_core_s0_beat);
            accepted = o_core_s0_vld && i_core_s0_rdy;
            next_cycle();
        end
        if (!accepted)
            report_failure("request beat was never accepted by the core");
        i_core_s0_rdy = 1'b0;
        i_dma_s0_vld  = 1'b0;
    endtask

    task automatic receive_completions(input int n_beats);
        logic [31:0] r;
        int          count;
        int          i;
        count = 0;
        for (i = 0; i < 100 && count < n_beats; i++)
        begin
            r = xorshift32();
            i_core_m_beat      = rand_rx_beat();
            i_core_m_beat.last = (count == n_beats - 1);
            i_core_m_vld       = r[0];
            i_dma_m_rdy        = r[1];
            #1;
            check_eq("o_dma_m_vld", 1'b0, o_dma_m_vld);
            check_eq("o_dma_m_beat", 0, o_dma_m_beat);
            check_eq("o_core_m_rdy", 1'b1, o_core_m_rdy);
            if (i_core_m_vld)
            begin
                model_cpl = i_core_m_beat.data;    // last beat wins
                count++;
            end
            next_cycle();
        end
        if (count < n_beats)
            report_failure("completion beats were not all accepted");
        i_core_m_vld = 1'b0;
    endtask

    // ********************
    // tests
    task automatic run_heartbeat();
        logic led_prev;
        int   n;
        int   p;
        check_eq("o_heartbeat_led", 1'b1, o_heartbeat_led);
        led_prev = o_heartbeat_led;
        n = 0;
        while (o_heartbeat_led === led_prev && n < 80)
        begin
            next_cycle();
            n++;
        end
        if (n >= 80)
            report_failure("heartbeat LED never toggled");
        for (p = 0; p < 8; p++)
        begin
            led_prev = o_heartbeat_led;
            n = 0;
            while (o_heartbeat_led === led_prev && n < 80)
            begin
                next_cycle();
                n++;
            end
            check_eq("heartbeat_period", 64, n);
        end
        report_test("heartbeat");
    endtask

    task automatic run_decode();
        logic [31:0] r;
        logic [3:0]  region;
        apb_data_t   rd;
        int          i;
        for (i = 0; i < N_APB; i++)
        begin
            r = xorshift32();
            case (r % 3)
                0: region = REGION_PCIE;
                1: region = REGION_DMA;
                default:
                begin
                    region = r[7:4];
                    if (region >= 4'h7 && region <= 4'h9)
                        region = region ^ 4'h8;    // move off mapped regions
                end
            endcase
            apb_access(r[31], {region, r[27:16]}, xorshift32(), r[11:8], rd);
        end
        report_test("decode");
    endtask

    task automatic run_cfg_regs();
        logic [31:0] r;
        logic [7:0]  offset;
        apb_data_t   data;
        int          t;
        int          i;
        for (i = 0; i < N_CFG; i++)
        begin
            r    = xorshift32();
            data = xorshift32();
            t    = int'(r % 9);
            if (t == 0)
                offset = CFG_REG_CTRL;
            else if (t <= 4)
                offset = CFG_REG_TX_BASE + 8'((t - 1) * 4);
            else
                offset = CFG_REG_RX_BASE + 8'((t - 5) * 4);
            if (t == 0 && r[8] && data[0])
                data[1] = 1'b0;    // no transaction here
            cfg_write(offset, data, r[11:8]);
            cfg_read_check(offset);
        end
        cfg_write(CFG_REG_CTRL, 32'h0, 4'h1);
        cfg_read_check(CFG_REG_CTRL);
        report_test("cfg_regs");
    endtask

    task automatic run_tlp();
        apb_data_t rd;
        int        polls;
        int        i;
        cfg_write(CFG_REG_CTRL, 32'h1, 4'h1);
        for (i = 0; i < 4; i++)
            cfg_write(CFG_REG_TX_BASE + 8'(i * 4), xorshift32(), 4'hF);
        cfg_write(CFG_REG_CTRL, 32'h3, 4'h1);
        send_request();
        receive_completions(1 + int'(xorshift32() % 3));
        model_done = 1'b1;
        rd    = '0;
        polls = 0;
        while (!rd[3] && polls < 16)
        begin
            cfg_read(CFG_REG_CTRL, rd);
            polls++;
        end
        if (!rd[3])
            report_failure("done was never set after the last completion beat");
        cfg_read_check(CFG_REG_CTRL);
        for (i = 0; i < 4; i++)
            cfg_read_check(CFG_REG_RX_BASE + 8'(i * 4));
        report_test("tlp");
    endtask

    task automatic run_abort();
        cfg_write(CFG_REG_CTRL, 32'h3, 4'h1);
        send_request();
        model_busy = 1'b1;    // waiting for completions
        cfg_read_check(CFG_REG_CTRL);
        check_eq("o_core_m_rdy", 1'b1, o_core_m_rdy);
        cfg_write(CFG_REG_CTRL, 32'h0, 4'h1);
        model_busy = 1'b0;
        cfg_read_check(CFG_REG_CTRL);
        check_steer_cycles(20);
        report_test("abort");
    endtask

    // ********************
    // main sequence
    initial
    begin
        i_apb_req        = '0;
        i_apb_sel        = 1'b0;
        i_pcie_apb_rdy   = 1'b0;
        i_pcie_apb_rdata = '0;
        i_dma_apb_rdy    = 1'b0;
        i_dma_apb_rdata  = '0;
        i_core_s0_rdy    = 1'b0;
        i_core_m_beat    = '0;
        i_core_m_vld     = 1'b0;
        i_dma_s0_beat    = '0;
        i_dma_s0_vld     = 1'b0;
        i_dma_m_rdy      = 1'b0;
        @(posedge s_pclk_rstn);
        next_cycle();
        run_heartbeat();
        run_decode();
        run_cfg_regs();
        check_steer_cycles(N_STEER);
        report_test("steer");
        run_tlp();
        run_abort();
        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge pclk);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("checks: %0d, errors: %0d", check_cnt, err_cnt + 1);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen
(
    output logic pclk,
    output logic s_pclk_rstn
);

    localparam int HALF_PERIOD = 5;    // 10 ns pclk
    localparam int RST_CYCLES  = 10;

    initial
    begin
        pclk = 1'b0;
        forever #HALF_PERIOD pclk = ~pclk;
    end

    // release just after an edge, already synchronous to pclk
    initial
    begin
        s_pclk_rstn = 1'b0;
        repeat (RST_CYCLES) @(posedge pclk);
        #1 s_pclk_rstn = 1'b1;
    end

endmodule
